/* bench/wb_tb_checks.svh */
// Reference model of GPR and CSR state for the writeback testbench
// Also holds the typed compare tasks and their error counters

int err_word = 0;                             // Mismatches on word results
int err_rd   = 0;                             // Mismatches on register indexes
int err_bit  = 0;                             // Mismatches on single-bit flags

wb_pkg::word_t gpr_m [32];                    // Entry 0 stays zero
wb_pkg::word_t mtvec_m;
wb_pkg::word_t mepc_m;
wb_pkg::word_t mscratch_m;
wb_pkg::word_t mcause_m;

// Model state
// ------------------------------
task automatic model_reset();
    for (int i = 0; i < 32; i++) begin
        gpr_m[i] = '0;
    end
    mtvec_m    = MTVEC_RST;                   // Only CSR with a nonzero reset
    mepc_m     = '0;
    mscratch_m = '0;
    mcause_m   = '0;
endtask

function automatic wb_pkg::word_t csr_model_read(input wb_pkg::csr_addr_t addr);
    case (addr)
        wb_pkg::CSR_MTVEC:    return mtvec_m;
        wb_pkg::CSR_MEPC:     return mepc_m;
        wb_pkg::CSR_MSCRATCH: return mscratch_m;
        wb_pkg::CSR_MCAUSE:   return mcause_m;
        default:              return '0;      // Unmapped reads zero
    endcase
endfunction

task automatic csr_model_write(input wb_pkg::csr_addr_t addr, input wb_pkg::word_t val);
    case (addr)
        wb_pkg::CSR_MTVEC:    mtvec_m    = val;
        wb_pkg::CSR_MEPC:     mepc_m     = val;
        wb_pkg::CSR_MSCRATCH: mscratch_m = val;
        wb_pkg::CSR_MCAUSE:   mcause_m   = val;
        default:              ;               // Unmapped writes vanish
    endcase
endtask

task automatic gpr_model_write(input wb_pkg::reg_addr_t rd, input wb_pkg::word_t val);
    if (rd != 5'd0) begin
        gpr_m[rd] = val;
    end
endtask

task automatic trap_model(input wb_pkg::word_t pc, input wb_pkg::word_t cause);
    mepc_m   = pc;
    mcause_m = cause;
endtask

// Compare tasks
// ------------------------------
task automatic check_word(input string name, input wb_pkg::word_t exp,
                          input wb_pkg::word_t act);
    if (act !== exp) begin
        err_word++;
        $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_rd(input string name, input wb_pkg::reg_addr_t exp,
                        input wb_pkg::reg_addr_t act);
    if (act !== exp) begin
        err_rd++;
        $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        err_bit++;
        $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
endtask

/* bench/wb_tb.sv */
// Writeback subsystem testbench
// Random ALU, CSR and control flow traffic checked against a GPR/CSR model
module wb_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam wb_pkg::word_t MTVEC_RST = 32'h0000_0200;  // Aligned trap vector
    localparam int N_INSTR     = 400;
    localparam int CYCLE_LIMIT = N_INSTR * 8 + 50;       // Worst case 8 per instr

    localparam int K_ALU    = 0;              // Instruction kinds
    localparam int K_CSR    = 1;
    localparam int K_TAKEN  = 2;              // Kinds from here up request a pc change
    localparam int K_ECALL  = 3;
    localparam int K_EBREAK = 4;
    localparam int K_IRQ    = 5;
    localparam int K_MRET   = 6;

    logic              g_clk;
    logic              g_resetn;
    wb_pkg::reg_addr_t s4_rd;
    wb_pkg::word_t     s4_opr_a, s4_opr_b, s4_pc, s4_instr;
    wb_pkg::uop_u      s4_uop;
    wb_pkg::fu_t       s4_fu;
    logic              s4_trap;
    wb_pkg::cause_t    s4_trap_code;
    logic              s4_p_valid, s4_p_busy;
    wb_pkg::reg_addr_t fwd_rd;
    wb_pkg::word_t     fwd_wdata;
    logic              fwd_csr;
    wb_pkg::word_t     trs_pc, trs_instr;
    logic              trs_valid;
    logic              cf_req, cf_ack;
    wb_pkg::word_t     cf_target;
    wb_pkg::reg_addr_t rs1_addr, rs2_addr;
    wb_pkg::word_t     rs1_data, rs2_data;

    logic [31:0]       lfsr_state = 32'hde1165e5;
    int                cur_kind;              // Kind of the instruction in the stage
    wb_pkg::reg_addr_t last_rd;               // Last retired destination
    int                cycle_cnt = 0;
    int                ack_delay;
    int                gap;

    `include "wb_tb_checks.svh"

    wb_top #(
        .MTVEC_RESET (MTVEC_RST)
    ) dut0 (.*);

    always #50 g_clk = ~g_clk;                // 100 ns period

    // Stimulus helpers
    // ------------------------------
    function automatic wb_pkg::word_t rand_bits(input int n);
        wb_pkg::word_t r;
        logic          fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};    // Taps 32, 22, 2, 1
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic wb_pkg::word_t expected_target();
        case (cur_kind)
            K_TAKEN: return s4_opr_a;
            K_MRET:  return mepc_m;
            default: return mtvec_m;          // All traps
        endcase
    endfunction

    task automatic drive_reads();
        rs1_addr <= last_rd;                  // Read back the last result
        rs2_addr <= 5'(rand_bits(5));
    endtask

    task automatic check_reads();
        check_word("gpr_rs1", gpr_m[rs1_addr], rs1_data);
        check_word("gpr_rs2", gpr_m[rs2_addr], rs2_data);
    endtask

    task automatic check_idle();
        check_bit("idle_busy", 1'b0, s4_p_busy);
        check_bit("idle_cf_req", 1'b0, cf_req);
        check_bit("idle_trs_valid", 1'b0, trs_valid);
        check_bit("idle_fwd_csr", 1'b0, fwd_csr);
    endtask

    task automatic drive_mtvec_read();
        wb_pkg::uop_u u;
        u          = '0;
        u.csr.read = 1'b1;
        cur_kind   = K_CSR;
        s4_fu        <= 5'b00001 << wb_pkg::FU_CSR;
        s4_uop       <= u;
        s4_opr_a     <= '0;
        s4_opr_b     <= 32'(wb_pkg::CSR_MTVEC);
        s4_rd        <= 5'd5;
        s4_pc        <= 32'h0000_1000;
        s4_instr     <= 32'h3050_22f3;        // csrr x5, mtvec
        s4_trap      <= 1'b0;
        s4_p_valid   <= 1'b1;
    endtask

    task automatic issue_random();
        wb_pkg::uop_u      u;
        wb_pkg::fu_t       fu;
        wb_pkg::csr_addr_t addr;
        logic              trap;
        logic [2:0]        sel;
        logic [1:0]        op;
        u        = 5'(rand_bits(5));          // Junk micro-op for ALU and IRQ
        fu       = 5'b00001 << wb_pkg::FU_ALU;
        trap     = 1'b0;
        cur_kind = K_ALU;
        sel      = 3'(rand_bits(3));
        case (sel)
            3'd3, 3'd4: begin
                cur_kind    = K_CSR;
                fu          = 5'b00001 << wb_pkg::FU_CSR;
                op          = 2'(rand_bits(2));
                u           = '0;
                u.csr.read  = 1'(rand_bits(1));
                u.csr.write = (op == 2'd1);   // At most one update op
                u.csr.set   = (op == 2'd2);
                u.csr.clear = (op == 2'd3);
            end
            3'd5: begin
                cur_kind = K_TAKEN;
                fu       = 5'b00001 << wb_pkg::FU_CFU;
                u.cfu    = wb_pkg::CFU_TAKEN;
            end
            3'd6: begin
                op = 2'(rand_bits(2));
                fu = 5'b00001 << wb_pkg::FU_CFU;
                if (op == 2'd0) begin
                    cur_kind = K_ECALL;
                    u.cfu    = wb_pkg::CFU_ECALL;
                end else if (op == 2'd1) begin
                    cur_kind = K_EBREAK;
                    u.cfu    = wb_pkg::CFU_EBREAK;
                end else begin
                    cur_kind = K_IRQ;         // Interrupt on an ALU op
                    fu       = 5'b00001 << wb_pkg::FU_ALU;
                    trap     = 1'b1;
                end
            end
            3'd7: begin
                cur_kind = K_MRET;
                fu       = 5'b00001 << wb_pkg::FU_CFU;
                u.cfu    = wb_pkg::CFU_MRET;
            end
            default: ;
        endcase
        sel = 3'(rand_bits(3));
        case (sel)
            3'd0:       addr = wb_pkg::CSR_MTVEC;
            3'd1, 3'd4: addr = wb_pkg::CSR_MEPC;
            3'd2, 3'd6: addr = wb_pkg::CSR_MSCRATCH;
            3'd3, 3'd5: addr = wb_pkg::CSR_MCAUSE;
            default:    addr = 12'h7c0 | 12'(rand_bits(4));   // Unmapped
        endcase
        s4_fu        <= fu;
        s4_uop       <= u;
        s4_trap      <= trap;
        s4_rd        <= 5'(rand_bits(5));
        s4_opr_a     <= rand_bits(32);
        s4_opr_b     <= (rand_bits(20) << 12) | 32'(addr);
        s4_pc        <= rand_bits(30) << 2;
        s4_instr     <= rand_bits(32);
        s4_trap_code <= 6'(rand_bits(6));
        s4_p_valid   <= 1'b1;
    endtask

    // Per-cycle checks
    // ------------------------------
    task automatic check_stage(output logic done);
        logic          is_cf;
        logic          exp_ret;
        wb_pkg::word_t old;
        wb_pkg::word_t nxt;
        is_cf   = (cur_kind >= K_TAKEN);
        exp_ret = is_cf ? cf_ack : 1'b1;      // Pc changes wait for the ack
        check_bit("trs_valid", exp_ret, trs_valid);
        check_bit("busy", is_cf && !cf_ack, s4_p_busy);
        check_bit("cf_req", is_cf, cf_req);
        check_bit("fwd_csr", cur_kind == K_CSR, fwd_csr);
        if (is_cf) begin
            check_word("cf_target", expected_target(), cf_target);
        end
        done = exp_ret;
        if (exp_ret) begin
            check_word("trs_pc", s4_pc, trs_pc);
            check_word("trs_instr", s4_instr, trs_instr);
            case (cur_kind)
                K_ALU: begin
                    check_rd("alu_fwd_rd", s4_rd, fwd_rd);
                    check_word("alu_fwd_wdata", s4_opr_a, fwd_wdata);
                    gpr_model_write(s4_rd, s4_opr_a);
                    last_rd = s4_rd;
                end
                K_CSR: begin
                    old = csr_model_read(s4_opr_b[11:0]);
                    nxt = old;
                    if (s4_uop.csr.read) begin
                        check_rd("csr_fwd_rd", s4_rd, fwd_rd);
                        check_word("csr_read", old, fwd_wdata);
                        gpr_model_write(s4_rd, old);
                        last_rd = s4_rd;
                    end
                    if (s4_uop.csr.write) nxt = s4_opr_a;
                    if (s4_uop.csr.set)   nxt = old | s4_opr_a;
                    if (s4_uop.csr.clear) nxt = old & ~s4_opr_a;
                    csr_model_write(s4_opr_b[11:0], nxt);
                end
                K_ECALL:  trap_model(s4_pc, 32'd11);
                K_EBREAK: trap_model(s4_pc, 32'd3);
                K_IRQ:    trap_model(s4_pc, 32'h8000_0000 | 32'(s4_trap_code[4:0]));
                default:  ;
            endcase
        end
    endtask

    task automatic run_to_retire();
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge g_clk);                 // Outputs settled mid-cycle
            check_reads();
            check_stage(done);
            @(posedge g_clk);
            drive_reads();
        end
    endtask

    // Control flow acknowledge, 0 to 3 cycles late
    always begin
        @(negedge g_clk);
        if (g_resetn && cf_req && !cf_ack) begin
            ack_delay = int'(rand_bits(2));
            repeat (ack_delay) @(negedge g_clk);
            @(posedge g_clk);
            cf_ack <= 1'b1;
            @(posedge g_clk);
            cf_ack <= 1'b0;
        end
    end

    // Run limit
    always @(posedge g_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors: word %0d, rd %0d, bit %0d", err_word, err_rd, err_bit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Main sequence
    // ------------------------------
    initial begin
        g_clk        = 1'b0;
        g_resetn     = 1'b0;
        s4_rd        = '0;
        s4_opr_a     = '0;
        s4_opr_b     = '0;
        s4_pc        = '0;
        s4_instr     = '0;
        s4_uop       = '0;
        s4_fu        = '0;
        s4_trap      = 1'b0;
        s4_trap_code = '0;
        s4_p_valid   = 1'b0;
        cf_ack       = 1'b0;
        rs1_addr     = '0;
        rs2_addr     = '0;
        last_rd      = '0;
        cur_kind     = K_ALU;
        model_reset();

        repeat (10) @(posedge g_clk);
        g_resetn <= 1'b1;

        for (int i = 0; i < 16; i++) begin   // Sweep every GPR after reset
            rs1_addr <= 5'(2 * i);
            rs2_addr <= 5'(2 * i + 1);
            @(negedge g_clk);
            check_idle();
            check_reads();
            @(posedge g_clk);
        end

        drive_mtvec_read();                   // Reset value of mtvec
        run_to_retire();

        for (int n = 0; n < N_INSTR; n++) begin
            gap = int'(rand_bits(2));
            repeat (gap) begin
                s4_p_valid <= 1'b0;
                @(negedge g_clk);
                check_reads();
                check_idle();
                @(posedge g_clk);
                drive_reads();
            end
            issue_random();
            run_to_retire();
        end

        s4_p_valid <= 1'b0;
        @(negedge g_clk);
        check_reads();                        // Last result read back
        check_idle();

        $display("Errors: word %0d, rd %0d, bit %0d", err_word, err_rd, err_bit);
        if (err_word + err_rd + err_bit == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* logic/wb_csr_file.sv */
// Machine CSR file for the writeback stage
// mtvec, mepc, mscratch and mcause with read/write/set/clear and trap capture
module wb_csr_file #(
    parameter wb_pkg::word_t MTVEC_RESET = 32'h0000_0100  // Trap vector at reset
) (
    input  logic              g_clk,          // Clock
    input  logic              g_resetn,       // Sync reset, active low

    input  logic              csr_en,         // Access on this cycle
    input  logic              csr_wr,         // Replace
    input  logic              csr_wr_set,     // OR in
    input  logic              csr_wr_clr,     // AND-NOT in
    input  wb_pkg::csr_addr_t csr_addr,       // Register select
    input  wb_pkg::word_t     csr_wdata,      // Write data
    output wb_pkg::word_t     csr_rdata,      // Value before the write
    output wb_pkg::word_t     csr_mtvec,      // Always-visible trap vector
    output wb_pkg::word_t     csr_mepc,       // Always-visible return pc

    input  logic              trap_take,      // Capture strobe
    input  wb_pkg::word_t     trap_pc,        // Goes to mepc
    input  wb_pkg::cause_t    trap_cause      // Goes to mcause
);

    wb_pkg::word_t mtvec;
    wb_pkg::word_t mepc;
    wb_pkg::word_t mscratch;
    wb_pkg::word_t mcause;

    // Address decode
    // ------------------------------
    logic sel_mtvec;
    logic sel_mepc;
    logic sel_mscratch;
    logic sel_mcause;

    assign sel_mtvec    = (csr_addr == wb_pkg::CSR_MTVEC);
    assign sel_mepc     = (csr_addr == wb_pkg::CSR_MEPC);
    assign sel_mscratch = (csr_addr == wb_pkg::CSR_MSCRATCH);
    assign sel_mcause   = (csr_addr == wb_pkg::CSR_MCAUSE);

    always_comb begin
        csr_rdata = '0;                       // Unknown address reads zero
        if (sel_mtvec)    csr_rdata = mtvec;
        if (sel_mepc)     csr_rdata = mepc;
        if (sel_mscratch) csr_rdata = mscratch;
        if (sel_mcause)   csr_rdata = mcause;
    end

    assign csr_mtvec = mtvec;
    assign csr_mepc  = mepc;

    // Next value
    // ------------------------------
    logic          wr_any;
    wb_pkg::word_t wr_val;

    assign wr_any = csr_en && (csr_wr || csr_wr_set || csr_wr_clr);

    always_comb begin
        if (csr_wr) begin
            wr_val = csr_wdata;
        end else if (csr_wr_set) begin
            wr_val = csr_rdata | csr_wdata;
        end else begin
            wr_val = csr_rdata & ~csr_wdata;  // Clear
        end
    end

    // Interrupt flag moves to bit 31
    wb_pkg::word_t cause_word;
    assign cause_word = {trap_cause[wb_pkg::CAUSE_INT_BIT], 26'd0, trap_cause[4:0]};

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mtvec    <= MTVEC_RESET;
            mepc     <= '0;
            mscratch <= '0;
            mcause   <= '0;
        end else if (trap_take) begin
            mepc     <= trap_pc;              // Return to trapping pc
            mcause   <= cause_word;
        end else if (wr_any) begin
            if (sel_mtvec)    mtvec    <= wr_val;
            if (sel_mepc)     mepc     <= wr_val;
            if (sel_mscratch) mscratch <= wr_val;
            if (sel_mcause)   mcause   <= wr_val;
        end
    end

    // Stage never retires a CSR op while a trap is acked
    a_no_wr_on_trap : assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(wr_any && trap_take));

endmodule

/* logic/wb_gpr_file.sv */
// General purpose register file, 31 x 32 bits
// One write port, two combinational read ports, x0 reads zero
module wb_gpr_file (
    input  logic              g_clk,          // Clock
    input  logic              g_resetn,       // Sync reset, active low

    input  logic              gpr_wen,        // Write enable
    input  wb_pkg::reg_addr_t gpr_rd,         // Write index
    input  wb_pkg::word_t     gpr_wdata,      // Write data

    input  wb_pkg::reg_addr_t rs1_addr,       // Read port 1 index
    output wb_pkg::word_t     rs1_data,       // Read port 1 data
    input  wb_pkg::reg_addr_t rs2_addr,       // Read port 2 index
    output wb_pkg::word_t     rs2_data        // Read port 2 data
);

    wb_pkg::word_t regs [1:31];               // No storage for x0

    // Write port
    // ------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;                // All GPRs start at zero
            end
        end else if (gpr_wen && (gpr_rd != '0)) begin
            regs[gpr_rd] <= gpr_wdata;        // x0 writes dropped
        end
    end

    // Read ports
    // ------------------------------
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // x0 stays zero, even right after a write aimed at it
    a_x0_zero : assert property (@(posedge g_clk) disable iff (!g_resetn)
        (gpr_wen && (gpr_rd == '0)) |=>
            ((rs1_addr != '0) || (rs1_data == '0)) &&
            ((rs2_addr != '0) || (rs2_data == '0)));

endmodule

/* logic/wb_pkg.sv */
// Writeback subsystem shared definitions
// Widths, unit positions, micro-op views, CSR addresses and trap causes
package wb_pkg;

    // Basic widths
    // ------------------------------
    typedef logic [31:0] word_t;      // Data, pc and instruction word
    typedef logic [ 4:0] reg_addr_t;  // GPR index
    typedef logic [11:0] csr_addr_t;  // CSR address
    typedef logic [ 4:0] fu_t;        // One-hot functional unit select

    // Functional unit bit positions within fu_t
    localparam int FU_ALU = 0;        // Integer ALU
    localparam int FU_MUL = 1;        // Multiplier, not present here
    localparam int FU_LSU = 2;        // Load/store, not present here
    localparam int FU_CFU = 3;        // Control flow unit
    localparam int FU_CSR = 4;        // CSR access unit

    // Micro-op encodings
    // ------------------------------
    typedef enum logic [4:0] {
        CFU_TAKEN  = 5'd1,            // Taken jump or branch
        CFU_EBREAK = 5'd2,            // Breakpoint trap
        CFU_ECALL  = 5'd3,            // Environment call trap
        CFU_MRET   = 5'd4             // Return from machine trap
    } cfu_op_e;

    // CSR view of the micro-op word
    typedef struct packed {
        logic read;                   // Copy old value into rd
        logic write;                  // Replace with write data
        logic set;                    // OR write data in
        logic clear;                  // AND-NOT write data in
        logic spare;                  // Unused
    } csr_op_t;

    // Same 5 bits, read per selected unit
    typedef union packed {
        csr_op_t csr;                 // Valid when CSR unit selected
        cfu_op_e cfu;                 // Valid when CFU unit selected
    } uop_u;

    // CSR map
    // ------------------------------
    localparam csr_addr_t CSR_MTVEC    = 12'h305; // Trap vector base
    localparam csr_addr_t CSR_MSCRATCH = 12'h340; // Scratch register
    localparam csr_addr_t CSR_MEPC     = 12'h341; // Trap return pc
    localparam csr_addr_t CSR_MCAUSE   = 12'h342; // Trap cause

    // Trap causes
    // ------------------------------
    // Bit 5 marks an interrupt, bits 4:0 hold the code
    typedef logic [5:0] cause_t;

    localparam int CAUSE_INT_BIT = 5;                // Interrupt flag position
    localparam cause_t CAUSE_EBREAK = 6'd3;          // Breakpoint
    localparam cause_t CAUSE_ECALL  = 6'd11;         // Environment call, M mode

endpackage

/* logic/wb_top.sv */
// Writeback subsystem top
// Connects the writeback stage to its CSR file and GPR file
module wb_top #(
    parameter wb_pkg::word_t MTVEC_RESET = 32'h0000_0100  // Trap vector at reset
) (
    input  logic              g_clk,          // Clock
    input  logic              g_resetn,       // Sync reset, active low

    input  wb_pkg::reg_addr_t s4_rd,          // Stage inputs
    input  wb_pkg::word_t     s4_opr_a,
    input  wb_pkg::word_t     s4_opr_b,
    input  wb_pkg::word_t     s4_pc,
    input  wb_pkg::word_t     s4_instr,
    input  wb_pkg::uop_u      s4_uop,
    input  wb_pkg::fu_t       s4_fu,
    input  logic              s4_trap,
    input  wb_pkg::cause_t    s4_trap_code,
    input  logic              s4_p_valid,
    output logic              s4_p_busy,

    output wb_pkg::reg_addr_t fwd_rd,         // Forwarding
    output wb_pkg::word_t     fwd_wdata,
    output logic              fwd_csr,

    output wb_pkg::word_t     trs_pc,         // Trace
    output wb_pkg::word_t     trs_instr,
    output logic              trs_valid,

    output logic              cf_req,         // Control flow
    output wb_pkg::word_t     cf_target,
    input  logic              cf_ack,

    input  wb_pkg::reg_addr_t rs1_addr,       // GPR read ports
    output wb_pkg::word_t     rs1_data,
    input  wb_pkg::reg_addr_t rs2_addr,
    output wb_pkg::word_t     rs2_data
);

    // Stage to register files
    // ------------------------------
    logic              gpr_wen;
    wb_pkg::reg_addr_t gpr_rd;
    wb_pkg::word_t     gpr_wdata;
    logic              csr_en, csr_wr, csr_wr_set, csr_wr_clr;
    wb_pkg::csr_addr_t csr_addr;
    wb_pkg::word_t     csr_wdata, csr_rdata, csr_mtvec, csr_mepc;
    logic              trap_take;
    wb_pkg::word_t     trap_pc;
    wb_pkg::cause_t    trap_cause;

    wb_writeback u_wb (.*);                   // Names match one to one

    wb_csr_file #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_csr (.*);

    wb_gpr_file u_gpr (.*);

endmodule

/* logic/wb_writeback.sv */
// Writeback stage of the integer pipeline
// Retires instructions into GPRs and CSRs and requests control flow changes
module wb_writeback (
    input  logic              g_clk,          // Clock
    input  logic              g_resetn,       // Sync reset, active low

    input  wb_pkg::reg_addr_t s4_rd,          // Destination register
    input  wb_pkg::word_t     s4_opr_a,       // Result or jump target
    input  wb_pkg::word_t     s4_opr_b,       // Holds CSR address
    input  wb_pkg::word_t     s4_pc,          // Instruction pc
    input  wb_pkg::word_t     s4_instr,       // Instruction word
    input  wb_pkg::uop_u      s4_uop,         // Micro-op
    input  wb_pkg::fu_t       s4_fu,          // Unit select, one-hot
    input  logic              s4_trap,        // Take an interrupt trap
    input  wb_pkg::cause_t    s4_trap_code,   // Interrupt cause
    input  logic              s4_p_valid,     // Stage inputs valid
    output logic              s4_p_busy,      // Stage holding its inputs

    output wb_pkg::reg_addr_t fwd_rd,         // Forwarded destination
    output wb_pkg::word_t     fwd_wdata,      // Forwarded result
    output logic              fwd_csr,        // CSR op in this stage

    output logic              gpr_wen,        // GPR write enable
    output wb_pkg::reg_addr_t gpr_rd,         // GPR write index
    output wb_pkg::word_t     gpr_wdata,      // GPR write data

    output logic              csr_en,         // CSR access
    output logic              csr_wr,         // CSR replace
    output logic              csr_wr_set,     // CSR bit set
    output logic              csr_wr_clr,     // CSR bit clear
    output wb_pkg::csr_addr_t csr_addr,       // CSR address
    output wb_pkg::word_t     csr_wdata,      // CSR write data
    input  wb_pkg::word_t     csr_rdata,      // CSR read data
    input  wb_pkg::word_t     csr_mtvec,      // Current trap vector
    input  wb_pkg::word_t     csr_mepc,       // Current return pc

    output logic              trap_take,      // Capture mepc and mcause
    output wb_pkg::word_t     trap_pc,        // Pc of trapping instruction
    output wb_pkg::cause_t    trap_cause,     // Cause to capture

    output wb_pkg::word_t     trs_pc,         // Trace pc
    output wb_pkg::word_t     trs_instr,      // Trace instruction
    output logic              trs_valid,      // Trace strobe, one per retire

    output logic              cf_req,         // Control flow change request
    output wb_pkg::word_t     cf_target,      // New pc
    input  logic              cf_ack          // Request accepted
);

    logic retire;                             // Instruction leaves this cycle
    logic cfu_done;                           // Request acked, still held

    // Unit decode
    // ------------------------------
    logic fu_alu;
    logic fu_mul;
    logic fu_lsu;
    logic fu_cfu;
    logic fu_csr;
    logic trap_in;

    assign fu_alu  = s4_p_valid && s4_fu[wb_pkg::FU_ALU];
    assign fu_mul  = s4_p_valid && s4_fu[wb_pkg::FU_MUL];
    assign fu_lsu  = s4_p_valid && s4_fu[wb_pkg::FU_LSU];
    assign fu_cfu  = s4_p_valid && s4_fu[wb_pkg::FU_CFU];
    assign fu_csr  = s4_p_valid && s4_fu[wb_pkg::FU_CSR];
    assign trap_in = s4_p_valid && s4_trap;   // Interrupt overrides the op

    assign retire  = s4_p_valid && !s4_p_busy;

    // CSR unit
    // ------------------------------
    logic csr_go;
    assign csr_go     = retire && fu_csr && !s4_trap;
    assign csr_en     = csr_go;
    assign csr_wr     = csr_go && s4_uop.csr.write;
    assign csr_wr_set = csr_go && s4_uop.csr.set;
    assign csr_wr_clr = csr_go && s4_uop.csr.clear;
    assign csr_addr   = s4_opr_b[11:0];       // Address rides on operand B
    assign csr_wdata  = s4_opr_a;

    // Control flow unit
    // ------------------------------
    logic cfu_taken;
    logic cfu_ecall;
    logic cfu_trap;
    logic cfu_mret;
    logic trap_any;
    logic cf_need;

    assign cfu_taken = fu_cfu && (s4_uop.cfu == wb_pkg::CFU_TAKEN);
    assign cfu_ecall = fu_cfu && (s4_uop.cfu == wb_pkg::CFU_ECALL);
    assign cfu_trap  = cfu_ecall || (fu_cfu && (s4_uop.cfu == wb_pkg::CFU_EBREAK));
    assign cfu_mret  = fu_cfu && (s4_uop.cfu == wb_pkg::CFU_MRET);
    assign trap_any  = cfu_trap || trap_in;
    assign cf_need   = cfu_taken || cfu_mret || trap_any;

    assign cf_req    = cf_need && !cfu_done;  // One request per instruction
    assign s4_p_busy = cf_need && !(cfu_done || cf_ack);

    always_comb begin
        if (trap_any) begin
            cf_target = csr_mtvec;            // Traps win over the op
        end else if (cfu_mret) begin
            cf_target = csr_mepc;
        end else begin
            cf_target = s4_opr_a;             // Taken jump, else don't care
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cfu_done <= 1'b0;
        end else begin
            cfu_done <= !retire && (cfu_done || (cf_req && cf_ack));
        end
    end

    // Trap capture
    // ------------------------------
    assign trap_take = cf_req && cf_ack && trap_any;
    assign trap_pc   = s4_pc;

    always_comb begin
        if (trap_in) begin
            trap_cause = {1'b1, s4_trap_code[4:0]};           // Interrupt
        end else if (cfu_ecall) begin
            trap_cause = wb_pkg::CAUSE_ECALL;
        end else begin
            trap_cause = wb_pkg::CAUSE_EBREAK;
        end
    end

    // GPR writeback and forwarding
    // ------------------------------
    logic csr_rd_wen;
    assign csr_rd_wen = fu_csr && s4_uop.csr.read;

    assign gpr_wen   = retire && !s4_trap && (fu_alu || csr_rd_wen);
    assign gpr_rd    = s4_rd;
    assign gpr_wdata = csr_rd_wen ? csr_rdata : s4_opr_a;   // Old CSR value
    assign fwd_rd    = s4_rd;
    assign fwd_wdata = gpr_wdata;
    assign fwd_csr   = fu_csr;

    // Trace
    assign trs_pc    = s4_pc;
    assign trs_instr = s4_instr;
    assign trs_valid = retire;

    // Only ALU, CFU and CSR units feed this stage
    a_fu_onehot : assert property (@(posedge g_clk) disable iff (!g_resetn)
        s4_p_valid |-> ($onehot(s4_fu) && !fu_mul && !fu_lsu));

    // Target held until the ack
    a_cf_stable : assert property (@(posedge g_clk) disable iff (!g_resetn)
        (cf_req && !cf_ack) |=> (cf_req && $stable(cf_target)));

endmodule

/* sim.f */
+incdir+bench
logic/wb_pkg.sv
logic/wb_gpr_file.sv
logic/wb_csr_file.sv
logic/wb_writeback.sv
logic/wb_top.sv
bench/wb_tb.sv
